// File: source/aluPkg.sv
package aluPkg;

  localparam int wordWidth = 64;
  localparam int halfWidth = 32;
  localparam int flagsWidth = 6;

  // flag word order, msb first: C O A S Z P
  localparam int flagC = 5;
  localparam int flagO = 4;
  localparam int flagA = 3;
  localparam int flagS = 2;
  localparam int flagZ = 1;
  localparam int flagP = 0;

  typedef logic [wordWidth-1:0] word_t;
  typedef logic [flagsWidth-1:0] flags_t;

  typedef enum logic [4:0] {
    opAdd64  = 5'd0,
    opAdd32  = 5'd1,
    opSub64  = 5'd2,
    opSub32  = 5'd3,
    opAnd64  = 5'd4,
    opAnd32  = 5'd5,
    opOr64   = 5'd6,
    opOr32   = 5'd7,
    opXor64  = 5'd8,
    opXor32  = 5'd9,
    opXnor64 = 5'd10,
    opXnor32 = 5'd11,
    opMov64  = 5'd12,
    opMov32  = 5'd13,
    opZxt8   = 5'd14, // zero extend to 64
    opZxt16  = 5'd15,
    opSxt8   = 5'd16, // sign extend to 64
    opSxt16  = 5'd17,
    opSxt32  = 5'd18,
    opCmov64 = 5'd19,
    opCset   = 5'd20
  } aluOp_t;

  // x86 style condition codes
  typedef enum logic [3:0] {
    condZ      = 4'd0,
    condNZ     = 4'd1,
    condS      = 4'd2,
    condNS     = 4'd3,
    condUGT    = 4'd4,
    condULE    = 4'd5,
    condUGE    = 4'd6,
    condULT    = 4'd7,
    condSGT    = 4'd8,
    condSLE    = 4'd9,
    condSGE    = 4'd10,
    condSLT    = 4'd11,
    condO      = 4'd12,
    condNO     = 4'd13,
    condP      = 4'd14,
    condAlways = 4'd15
  } condCode_t;

endpackage

// File: source/condEval.sv
`timescale 1ns/100ps

module condEval
(
  input  aluPkg::flags_t    flags,
  input  aluPkg::condCode_t cond,
  output logic              condTrue
);

  import aluPkg::*;

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;
  logic sNeO; // signed less-than

  assign c = flags[flagC];
  assign o = flags[flagO];
  assign s = flags[flagS];
  assign z = flags[flagZ];
  assign p = flags[flagP];
  assign sNeO = s ^ o;

  always_comb
  begin
    case (cond)
      condZ:      condTrue = z;
      condNZ:     condTrue = ~z;
      condS:      condTrue = s;
      condNS:     condTrue = ~s;
      condUGT:    condTrue = ~c & ~z;
      condULE:    condTrue = c | z;
      condUGE:    condTrue = ~c;
      condULT:    condTrue = c; // borrow set
      condSGT:    condTrue = ~sNeO & ~z;
      condSLE:    condTrue = sNeO | z;
      condSGE:    condTrue = ~sNeO;
      condSLT:    condTrue = sNeO;
      condO:      condTrue = o;
      condNO:     condTrue = ~o;
      condP:      condTrue = p;
      default:    condTrue = 1'b1; // condAlways
    endcase
  end

endmodule

// File: source/aluAdder.sv
`timescale 1ns/100ps

module aluAdder
(
  input  aluPkg::word_t a,
  input  aluPkg::word_t b,
  input  logic          sub,
  output aluPkg::word_t sum,
  output logic          carry64,
  output logic          carry32,
  output logic          nibbleCarry,
  output logic          ovf64,
  output logic          ovf32
);

  import aluPkg::*;

  word_t                bEff;
  logic [wordWidth:0]   full;
  logic [halfWidth:0]   low;  // low half again, for its carry out
  logic [4:0]           nib;

  // subtract as a + ~b + 1
  assign bEff = sub ? ~b : b;

  assign full = {1'b0, a} + {1'b0, bEff} + {{wordWidth{1'b0}}, sub};
  assign low  = {1'b0, a[halfWidth-1:0]} + {1'b0, bEff[halfWidth-1:0]}
              + {{halfWidth{1'b0}}, sub};
  assign nib  = {1'b0, a[3:0]} + {1'b0, bEff[3:0]} + {4'b0, sub};

  assign sum         = full[wordWidth-1:0];
  assign carry64     = full[wordWidth];
  assign carry32     = low[halfWidth];
  assign nibbleCarry = nib[4];

  // operands agree in sign, sum does not
  assign ovf64 = (a[wordWidth-1] ~^ bEff[wordWidth-1])
               & (sum[wordWidth-1] ^ a[wordWidth-1]);
  assign ovf32 = (a[halfWidth-1] ~^ bEff[halfWidth-1])
               & (sum[halfWidth-1] ^ a[halfWidth-1]);

endmodule

// File: source/aluLogic.sv
`timescale 1ns/100ps

module aluLogic
(
  input  aluPkg::aluOp_t op,
  input  aluPkg::word_t  val1,
  input  aluPkg::word_t  val2,
  input  logic           condTrue,
  output aluPkg::word_t  logicResult
);

  import aluPkg::*;

  word_t valAnd;
  word_t valOr;
  word_t valXor;

  assign valAnd = val1 & val2;
  assign valOr  = val1 | val2;
  assign valXor = val1 ^ val2;

  always_comb
  begin
    case (op)
      opAnd64:
        logicResult = valAnd;
      opAnd32:
        logicResult = {{halfWidth{1'b0}}, valAnd[halfWidth-1:0]};
      opOr64:
        logicResult = valOr;
      opOr32:
        logicResult = {{halfWidth{1'b0}}, valOr[halfWidth-1:0]};
      opXor64:
        logicResult = valXor;
      opXor32:
        logicResult = {{halfWidth{1'b0}}, valXor[halfWidth-1:0]};
      opXnor64:
        logicResult = ~valXor;
      opXnor32:
        logicResult = {{halfWidth{1'b0}}, ~valXor[halfWidth-1:0]};

      // moves and extensions all take val2
      opMov64:
        logicResult = val2;
      opMov32:
        logicResult = {{halfWidth{1'b0}}, val2[halfWidth-1:0]};
      opZxt8:
        logicResult = {{(wordWidth-8){1'b0}}, val2[7:0]};
      opZxt16:
        logicResult = {{(wordWidth-16){1'b0}}, val2[15:0]};
      opSxt8:
        logicResult = {{(wordWidth-8){val2[7]}}, val2[7:0]};
      opSxt16:
        logicResult = {{(wordWidth-16){val2[15]}}, val2[15:0]};
      opSxt32:
        logicResult = {{(wordWidth-halfWidth){val2[halfWidth-1]}}, val2[halfWidth-1:0]};

      opCmov64:
        logicResult = condTrue ? val2 : val1;
      opCset:
        logicResult = {{(wordWidth-1){1'b0}}, condTrue};

      // add and sub come from the adder
      default:
        logicResult = '0;
    endcase
  end

endmodule

// File: source/aluRetire.sv
`timescale 1ns/100ps

module aluRetire
(
  input  logic           clk,
  input  logic           rst,
  input  logic           dataEn,
  input  aluPkg::aluOp_t op,
  input  aluPkg::word_t  sum,
  input  aluPkg::word_t  logicResult,
  input  logic           carry64,
  input  logic           carry32,
  input  logic           nibbleCarry,
  input  logic           ovf64,
  input  logic           ovf32,
  output aluPkg::word_t  result,
  output aluPkg::flags_t flagsOut,
  output logic           setsFlags,
  output logic           retEn
);

  import aluPkg::*;

  logic   isArith;
  logic   isSub;
  logic   isLogic;
  logic   isHalf; // any 32-bit form
  logic   flagOp;
  word_t  resNext;
  flags_t flagsNext;

  assign isArith = (op == opAdd64) || (op == opAdd32) || (op == opSub64) || (op == opSub32);
  assign isSub   = (op == opSub64) || (op == opSub32);
  assign isLogic = (op == opAnd64) || (op == opAnd32) || (op == opOr64) || (op == opOr32)
                || (op == opXor64) || (op == opXor32) || (op == opXnor64) || (op == opXnor32);
  assign isHalf  = (op == opAdd32) || (op == opSub32) || (op == opAnd32) || (op == opOr32)
                || (op == opXor32) || (op == opXnor32);
  assign flagOp  = isArith | isLogic;

  always_comb
  begin
    resNext = isArith ? sum : logicResult;
    if (isHalf)
      resNext[wordWidth-1:halfWidth] = '0;
  end

  always_comb
  begin
    flagsNext = '0;
    if (flagOp)
    begin
      // borrow is the inverted carry
      flagsNext[flagC] = isArith & ((isHalf ? carry32 : carry64) ^ isSub);
      flagsNext[flagO] = isArith & (isHalf ? ovf32 : ovf64);
      flagsNext[flagA] = isArith & (nibbleCarry ^ isSub);
      flagsNext[flagS] = isHalf ? resNext[halfWidth-1] : resNext[wordWidth-1];
      flagsNext[flagZ] = (resNext == '0); // upper half already cleared
      flagsNext[flagP] = ~^resNext[7:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      retEn     <= 1'b0;
      setsFlags <= 1'b0;
      result    <= '0;
      flagsOut  <= '0;
    end
    else
    begin
      retEn     <= dataEn;
      setsFlags <= dataEn & flagOp;
      if (dataEn)
      begin
        result   <= resNext;
        flagsOut <= flagsNext;
      end
    end
  end

endmodule

// File: source/aluTop.sv
`timescale 1ns/100ps

module aluTop
(
  input  logic              clk,
  input  logic              rst,
  input  logic              dataEn,
  input  aluPkg::aluOp_t    op,
  input  aluPkg::condCode_t cond,
  input  aluPkg::word_t     val1,
  input  aluPkg::word_t     val2,
  input  aluPkg::flags_t    flagsIn,
  output aluPkg::word_t     result,
  output aluPkg::flags_t    flagsOut,
  output logic              setsFlags,
  output logic              retEn
);

  import aluPkg::*;

  logic  condTrue;
  word_t sum;
  word_t logicResult;
  logic  carry64;
  logic  carry32;
  logic  nibbleCarry;
  logic  ovf64;
  logic  ovf32;
  wire   subSel = (op == opSub64) || (op == opSub32);

  condEval u_condEval (
    .flags    (flagsIn),
    .cond     (cond),
    .condTrue (condTrue)
  );

  aluAdder u_aluAdder (
    .a           (val1),
    .b           (val2),
    .sub         (subSel),
    .sum         (sum),
    .carry64     (carry64),
    .carry32     (carry32),
    .nibbleCarry (nibbleCarry),
    .ovf64       (ovf64),
    .ovf32       (ovf32)
  );

  aluLogic u_aluLogic (
    .op          (op),
    .val1        (val1),
    .val2        (val2),
    .condTrue    (condTrue),
    .logicResult (logicResult)
  );

  // single register stage lives here
  aluRetire u_aluRetire (
    .clk         (clk),
    .rst         (rst),
    .dataEn      (dataEn),
    .op          (op),
    .sum         (sum),
    .logicResult (logicResult),
    .carry64     (carry64),
    .carry32     (carry32),
    .nibbleCarry (nibbleCarry),
    .ovf64       (ovf64),
    .ovf32       (ovf32),
    .result      (result),
    .flagsOut    (flagsOut),
    .setsFlags   (setsFlags),
    .retEn       (retEn)
  );

endmodule

// File: bench/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// x86 condition decode over C O S Z P
function automatic logic condHolds(input condCode_t cc, input flags_t f);
  logic c;
  logic o;
  logic s;
  logic z;
  logic p;
  c = f[flagC];
  o = f[flagO];
  s = f[flagS];
  z = f[flagZ];
  p = f[flagP];
  case (cc)
    condZ:   return z;
    condNZ:  return !z;
    condS:   return s;
    condNS:  return !s;
    condUGT: return !c && !z;
    condULE: return c || z;
    condUGE: return !c;
    condULT: return c;
    condSGT: return (s == o) && !z;
    condSLE: return (s != o) || z;
    condSGE: return s == o;
    condSLT: return s != o;
    condO:   return o;
    condNO:  return !o;
    condP:   return p;
    default: return 1'b1;
  endcase
endfunction

// expected result, flags and setsFlags for one operation
function automatic void aluRef(
  input  aluOp_t    opIn,
  input  condCode_t cc,
  input  word_t     a,
  input  word_t     b,
  input  flags_t    fIn,
  output word_t     res,
  output flags_t    flg,
  output logic      sf
);
  logic               half;
  logic               arith;
  logic               flagOp;
  word_t              mask;
  word_t              ua;
  word_t              ub;
  logic [64:0]        uSum;
  logic signed [65:0] sa;
  logic signed [65:0] sb;
  logic signed [65:0] sRes;
  logic signed [65:0] sTrunc;
  logic               carry;
  logic               aux;
  logic               ovf;
  half   = opIn inside {opAdd32, opSub32, opAnd32, opOr32, opXor32, opXnor32};
  arith  = opIn inside {opAdd64, opAdd32, opSub64, opSub32};
  flagOp = opIn inside {[opAdd64:opXnor32]};
  mask   = half ? 64'h0000_0000_ffff_ffff : 64'hffff_ffff_ffff_ffff;
  ua     = a & mask;
  ub     = b & mask;
  sa     = half ? {{34{a[31]}}, a[31:0]} : {{2{a[63]}}, a};
  sb     = half ? {{34{b[31]}}, b[31:0]} : {{2{b[63]}}, b};
  sRes   = '0;
  carry  = 1'b0;
  aux    = 1'b0;
  ovf    = 1'b0;
  res    = '0;
  flg    = '0;
  sf     = 1'b0;
  case (opIn)
    opAdd64, opAdd32:
    begin
      uSum  = {1'b0, ua} + {1'b0, ub};
      res   = uSum[63:0] & mask;
      carry = half ? uSum[32] : uSum[64];
      aux   = a[3:0] > (4'd15 - b[3:0]);
      sRes  = sa + sb;
    end
    opSub64, opSub32:
    begin
      res   = (ua - ub) & mask;
      carry = ua < ub; // borrow
      aux   = a[3:0] < b[3:0];
      sRes  = sa - sb;
    end
    opAnd64, opAnd32:   res = (a & b) & mask;
    opOr64, opOr32:     res = (a | b) & mask;
    opXor64, opXor32:   res = (a ^ b) & mask;
    opXnor64, opXnor32: res = ~(a ^ b) & mask;
    opMov64:  res = b;
    opMov32:  res = b & 64'h0000_0000_ffff_ffff;
    opZxt8:   res = b & 64'h0000_0000_0000_00ff;
    opZxt16:  res = b & 64'h0000_0000_0000_ffff;
    opSxt8:   res = {{56{b[7]}}, b[7:0]};
    opSxt16:  res = {{48{b[15]}}, b[15:0]};
    opSxt32:  res = {{32{b[31]}}, b[31:0]};
    opCmov64: res = condHolds(cc, fIn) ? b : a;
    opCset:   res = condHolds(cc, fIn) ? 64'd1 : 64'd0;
    default:  res = '0;
  endcase
  if (arith)
  begin
    // exact sum no longer fits the width
    sTrunc = half ? {{34{res[31]}}, res[31:0]} : {{2{res[63]}}, res};
    ovf    = sRes != sTrunc;
  end
  if (flagOp)
  begin
    sf         = 1'b1;
    flg[flagC] = carry;
    flg[flagO] = ovf;
    flg[flagA] = aux;
    flg[flagS] = half ? res[31] : res[63];
    flg[flagZ] = res == '0;
    flg[flagP] = ($countones(res[7:0]) % 2) == 0;
  end
endfunction

`endif

// File: bench/aluTb.sv
`timescale 1ns/100ps

module aluTb;

  import aluPkg::*;

  `include "aluModel.svh"

  logic      clk;
  logic      rst;
  logic      dataEn;
  aluOp_t    op;
  condCode_t cond;
  word_t     val1;
  word_t     val2;
  flags_t    flagsIn;
  word_t     result;
  flags_t    flagsOut;
  logic      setsFlags;
  logic      retEn;

  int opsIssued = 0;
  int opsChecked = 0;

  aluTop u_aluTop (
    .clk       (clk),
    .rst       (rst),
    .dataEn    (dataEn),
    .op        (op),
    .cond      (cond),
    .val1      (val1),
    .val2      (val2),
    .flagsIn   (flagsIn),
    .result    (result),
    .flagsOut  (flagsOut),
    .setsFlags (setsFlags),
    .retEn     (retEn)
  );

  always #50 clk = ~clk;

  task automatic checkValue(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic word_t edgeValue(input int unsigned idx);
    case (idx % 8)
      0:       return 64'd0;
      1:       return 64'd1;
      2:       return 64'hffff_ffff_ffff_ffff;
      3:       return 64'h7fff_ffff_ffff_ffff; // 64-bit sign boundary
      4:       return 64'h8000_0000_0000_0000;
      5:       return 64'h0000_0000_7fff_ffff; // 32-bit sign boundary
      6:       return 64'h0000_0000_8000_0000;
      default: return 64'h0000_0000_ffff_ffff;
    endcase
  endfunction

  function automatic word_t randWord();
    return {$urandom, $urandom};
  endfunction

  function automatic word_t pickOperand();
    if ($urandom % 3 == 0)
      return edgeValue($urandom % 8);
    return randWord();
  endfunction

  function automatic flags_t randFlags();
    return flags_t'($urandom % 64);
  endfunction

  task automatic issueOp(input aluOp_t o, input condCode_t c, input word_t a, input word_t b,
                         input flags_t f);
    @(negedge clk);
    dataEn  = 1'b1;
    op      = o;
    cond    = c;
    val1    = a;
    val2    = b;
    flagsIn = f;
    opsIssued++;
  endtask

  // operands keep changing while idle
  task automatic idleGap(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(negedge clk);
      dataEn = 1'b0;
      val1   = randWord();
      val2   = randWord();
    end
  endtask

  task automatic waitDrained();
    int cycles;
    cycles = 0;
    while (opsChecked != opsIssued && cycles < 20)
    begin
      @(negedge clk);
      cycles++;
    end
    if (opsChecked != opsIssued)
    begin
      $display("timeout: %0d operations issued but only %0d came back with retEn",
               opsIssued, opsChecked);
      $display("SIMULATION FAILED");
      $fatal(1, "outputs never drained");
    end
  endtask

  // compare process
  initial
  begin : compare
    word_t  expRes;
    flags_t expFlags;
    logic   expSf;
    logic   capRst;
    logic   capEn;
    logic   anyAccepted;
    expRes      = '0;
    expFlags    = '0;
    expSf       = 1'b0;
    anyAccepted = 1'b0;
    forever
    begin
      @(posedge clk);
      capRst = rst;
      capEn  = dataEn & ~rst;
      if (capEn)
        aluRef(op, cond, val1, val2, flagsIn, expRes, expFlags, expSf);
      @(negedge clk);
      #10; // next inputs already applied
      if (capRst)
      begin
        anyAccepted = 1'b0;
        checkValue({63'd0, retEn}, 64'd0, "retEn in reset");
        checkValue({63'd0, setsFlags}, 64'd0, "setsFlags in reset");
        checkValue(result, 64'd0, "result in reset");
        checkValue({58'd0, flagsOut}, 64'd0, "flagsOut in reset");
      end
      else if (capEn)
      begin
        anyAccepted = 1'b1;
        checkValue({63'd0, retEn}, 64'd1, "retEn after accept");
        checkValue(result, expRes, "result");
        checkValue({58'd0, flagsOut}, {58'd0, expFlags}, "flagsOut");
        checkValue({63'd0, setsFlags}, {63'd0, expSf}, "setsFlags");
        opsChecked++;
      end
      else
      begin
        checkValue({63'd0, retEn}, 64'd0, "retEn while idle");
        checkValue({63'd0, setsFlags}, 64'd0, "setsFlags while idle");
        if (!anyAccepted)
        begin
          checkValue(result, 64'd0, "result after reset");
          checkValue({58'd0, flagsOut}, 64'd0, "flagsOut after reset");
        end
      end
    end
  end

  initial
  begin
    clk     = 1'b0;
    rst     = 1'b1;
    dataEn  = 1'b0;
    op      = opAdd64;
    cond    = condAlways;
    val1    = '0;
    val2    = '0;
    flagsIn = '0;
    void'($urandom(53228));
    for (int i = 0; i < 3; i++)
      @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idleGap(2);

    // every edge pair for add and sub first
    for (int k = 0; k < 4; k++)
      for (int i = 0; i < 8; i++)
        for (int j = 0; j < 8; j++)
        begin
          issueOp(aluOp_t'(k[4:0]), condAlways, edgeValue(i), edgeValue(j), randFlags());
          idleGap($urandom % 3);
        end
    for (int i = 0; i < 200; i++)
    begin
      issueOp(aluOp_t'($urandom % 4), condAlways, pickOperand(), pickOperand(), randFlags());
      idleGap($urandom % 3);
    end

    for (int i = 0; i < 160; i++)
    begin
      issueOp(aluOp_t'(4 + $urandom % 8), condAlways, pickOperand(), pickOperand(), randFlags());
      idleGap($urandom % 3);
    end

    // moves and extensions
    for (int k = 12; k < 19; k++)
      for (int i = 0; i < 12; i++)
      begin
        issueOp(aluOp_t'(k[4:0]), condAlways, randWord(), pickOperand(), randFlags());
        idleGap($urandom % 3);
      end

    for (int c = 0; c < 16; c++)
      for (int i = 0; i < 8; i++)
      begin
        issueOp(opCmov64, condCode_t'(c[3:0]), randWord(), randWord(), randFlags());
        issueOp(opCset, condCode_t'(c[3:0]), randWord(), randWord(), randFlags());
        idleGap($urandom % 4);
      end

    idleGap(1);
    waitDrained();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: src.f
+incdir+bench
source/aluPkg.sv
source/condEval.sv
source/aluAdder.sv
source/aluLogic.sv
source/aluRetire.sv
source/aluTop.sv
bench/aluTb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module aluTb -f src.f -Mdir obj_dir
	-./obj_dir/ValuTb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
